/* logic/sixFiveTypes.sv */
package sixFiveTypes;

    localparam int laneCount = 4; // bytes per fetch word, one lane each

    // zero is the table default for unfilled encodings
    typedef enum logic [5:0] {
        cmdNone = 6'd0,
        cmdBrk, cmdJsr, cmdRti, cmdRts, cmdLdy, cmdCpy, cmdCpx, cmdBit,
        cmdSty, cmdPhp, cmdPlp, cmdPha, cmdPla, cmdDey, cmdTay, cmdIny,
        cmdInx, cmdJmp,
        cmdBpl, cmdBmi, cmdBvc, cmdBvs, cmdBcc, cmdBcs, cmdBne, cmdBeq,
        cmdClc, cmdSec, cmdCli, cmdSei, cmdTya, cmdClv, cmdCld, cmdSed,
        cmdOra, cmdAnd, cmdEor, cmdAdc, cmdSta, cmdLda, cmdCmp, cmdSbc,
        cmdLdx, cmdAsl, cmdRol, cmdLsr, cmdRor, cmdStx, cmdDec, cmdInc,
        cmdAslA, cmdRolA, cmdLsrA, cmdRorA, cmdTxa, cmdTax, cmdDex, cmdNop,
        cmdTxs, cmdTsx
    } cmdT;

    typedef enum logic [3:0] {
        modeImpl = 4'd0,
        modeAcc,
        modeImm,
        modeZpg,
        modeZpgX,
        modeZpgY,
        modeAbs,
        modeAbsX,
        modeAbsY,
        modeInd,
        modeXind,
        modeIndY,
        modeRel
    } modeT;

    // raw byte from fetch, aaabbbcc fields for the decoder
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [2:0] a;
            logic [2:0] b;
            logic [1:0] c;
        } fields;
    } opcodeT;

    typedef logic [1:0] lenT; // 1 to 3 bytes

    function automatic lenT instLength(input modeT mode);
        case (mode)
            modeImpl, modeAcc: return 2'd1;
            modeAbs, modeAbsX, modeAbsY, modeInd: return 2'd3;
            default: return 2'd2; // imm, zero page, indexed indirect, rel
        endcase
    endfunction

endpackage

/* logic/laneResultIf.sv */
`timescale 1ns/10ps

// one lane's decode result on its way to the boundary picker
interface laneResultIf;
    import sixFiveTypes::*;

    logic valid; // one-cycle strobe per word
    cmdT  cmd;
    modeT mode;
    lenT  len;

    modport lane (
        output valid, cmd, mode, len
    );

    modport picker (
        input valid, cmd, mode, len
    );

endinterface

/* logic/fetchWindow.sv */
`timescale 1ns/10ps

module fetchWindow (
    input  logic                                 clk,
    input  logic                                 rstN,
    input  logic                                 fetchValid,
    input  logic [8*sixFiveTypes::laneCount-1:0] fetchData,
    output logic                                 byteValid,
    output sixFiveTypes::opcodeT                 laneByte [sixFiveTypes::laneCount]
);
    import sixFiveTypes::*;

    logic [8*laneCount-1:0] wordReg;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            byteValid <= 1'b0;
        end else begin
            byteValid <= fetchValid;
        end
    end

    // word held between fetches so the lanes stay quiet
    always_ff @(posedge clk) begin
        if (fetchValid) begin
            wordReg <= fetchData;
        end
    end

    // byte 0 is the oldest in program order
    for (genvar i = 0; i < laneCount; i++) begin : splitBytes
        assign laneByte[i].raw = wordReg[8*i +: 8];
    end

endmodule

/* logic/opcodeDecoder.sv */
`timescale 1ns/10ps

module opcodeDecoder (
    input  sixFiveTypes::opcodeT opcode,
    output sixFiveTypes::cmdT    cmd,
    output sixFiveTypes::modeT   mode
);
    import sixFiveTypes::*;

    logic [2:0] a;
    logic [2:0] b;
    logic [1:0] c;

    assign a = opcode.fields.a;
    assign b = opcode.fields.b;
    assign c = opcode.fields.c;

    // shift and memory group of the c = 2 column, selected by a
    function automatic cmdT rmwCmd(input logic [2:0] sel);
        case (sel)
            3'b000: return cmdAsl;
            3'b001: return cmdRol;
            3'b010: return cmdLsr;
            3'b011: return cmdRor;
            3'b100: return cmdStx;
            3'b101: return cmdLdx;
            3'b110: return cmdDec;
            default: return cmdInc;
        endcase
    endfunction

    always_comb begin
        cmd  = cmdNone;
        mode = modeImpl;

        case (c)
            2'b00: begin
                case (b)
                    3'b000: begin
                        case (a)
                            3'b000: cmd = cmdBrk;
                            3'b001: begin
                                cmd  = cmdJsr;
                                mode = modeAbs;
                            end
                            3'b010: cmd = cmdRti;
                            3'b011: cmd = cmdRts;
                            3'b101: begin
                                cmd  = cmdLdy;
                                mode = modeImm;
                            end
                            3'b110: begin
                                cmd  = cmdCpy;
                                mode = modeImm;
                            end
                            default: begin
                                cmd  = cmdCpx;
                                mode = modeImm;
                            end
                        endcase
                    end
                    3'b001: begin
                        mode = modeZpg;
                        casez (a)
                            3'b00?: cmd = cmdBit;
                            3'b100: cmd = cmdSty;
                            3'b101: cmd = cmdLdy;
                            3'b110: cmd = cmdCpy;
                            default: cmd = cmdCpx;
                        endcase
                    end
                    3'b010: begin
                        case (a) // stack and index register ops
                            3'b000: cmd = cmdPhp;
                            3'b001: cmd = cmdPlp;
                            3'b010: cmd = cmdPha;
                            3'b011: cmd = cmdPla;
                            3'b100: cmd = cmdDey;
                            3'b101: cmd = cmdTay;
                            3'b110: cmd = cmdIny;
                            default: cmd = cmdInx;
                        endcase
                    end
                    3'b011: begin
                        mode = modeAbs;
                        case (a)
                            3'b001: cmd = cmdBit;
                            3'b010: cmd = cmdJmp;
                            3'b011: begin
                                cmd  = cmdJmp;
                                mode = modeInd; // the one indirect jump
                            end
                            3'b100: cmd = cmdSty;
                            3'b101: cmd = cmdLdy;
                            3'b110: cmd = cmdCpy;
                            default: cmd = cmdCpx;
                        endcase
                    end
                    3'b100: begin
                        mode = modeRel;
                        case (a)
                            3'b000: cmd = cmdBpl;
                            3'b001: cmd = cmdBmi;
                            3'b010: cmd = cmdBvc;
                            3'b011: cmd = cmdBvs;
                            3'b100: cmd = cmdBcc;
                            3'b101: cmd = cmdBcs;
                            3'b110: cmd = cmdBne;
                            default: cmd = cmdBeq;
                        endcase
                    end
                    3'b101: begin
                        mode = modeZpgX;
                        cmd  = (a == 3'b100) ? cmdSty : cmdLdy;
                    end
                    3'b110: begin
                        case (a) // flag ops plus tya
                            3'b000: cmd = cmdClc;
                            3'b001: cmd = cmdSec;
                            3'b010: cmd = cmdCli;
                            3'b011: cmd = cmdSei;
                            3'b100: cmd = cmdTya;
                            3'b101: cmd = cmdClv;
                            3'b110: cmd = cmdCld;
                            default: cmd = cmdSed;
                        endcase
                    end
                    default: begin
                        mode = modeAbsX;
                        cmd  = cmdLdy;
                    end
                endcase
            end

            2'b01: begin
                case (b) // ALU group, mode straight from b
                    3'b000: mode = modeXind;
                    3'b001: mode = modeZpg;
                    3'b010: mode = modeImm;
                    3'b011: mode = modeAbs;
                    3'b100: mode = modeIndY;
                    3'b101: mode = modeZpgX;
                    3'b110: mode = modeAbsY;
                    default: mode = modeAbsX;
                endcase
                case (a)
                    3'b000: cmd = cmdOra;
                    3'b001: cmd = cmdAnd;
                    3'b010: cmd = cmdEor;
                    3'b011: cmd = cmdAdc;
                    3'b100: cmd = cmdSta;
                    3'b101: cmd = cmdLda;
                    3'b110: cmd = cmdCmp;
                    default: cmd = cmdSbc;
                endcase
            end

            default: begin // c = 3 lands here too
                case (b)
                    3'b000: begin
                        cmd  = cmdLdx;
                        mode = modeImm;
                    end
                    3'b001: begin
                        cmd  = rmwCmd(a);
                        mode = modeZpg;
                    end
                    3'b010: begin
                        mode = a[2] ? modeImpl : modeAcc; // transfers from a = 4 up
                        case (a) // accumulator shifts and transfers
                            3'b000: cmd = cmdAslA;
                            3'b001: cmd = cmdRolA;
                            3'b010: cmd = cmdLsrA;
                            3'b011: cmd = cmdRorA;
                            3'b100: cmd = cmdTxa;
                            3'b101: cmd = cmdTax;
                            3'b110: cmd = cmdDex;
                            default: cmd = cmdNop;
                        endcase
                    end
                    3'b011: begin
                        cmd  = rmwCmd(a);
                        mode = modeAbs;
                    end
                    3'b101: begin
                        cmd  = rmwCmd(a);
                        // stx and ldx index with y
                        mode = (a == 3'b100 || a == 3'b101) ? modeZpgY : modeZpgX;
                    end
                    3'b110: cmd = (a == 3'b100) ? cmdTxs : cmdTsx;
                    3'b111: begin
                        mode = modeAbsX;
                        cmd  = (a == 3'b100) ? cmdInc : rmwCmd(a);
                    end
                    default: ; // b = 4 left unfilled
                endcase
            end
        endcase
    end

endmodule

/* logic/predecodeLane.sv */
`timescale 1ns/10ps

module predecodeLane (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 byteValid,
    input  sixFiveTypes::opcodeT laneByte,
    laneResultIf.lane            result
);
    import sixFiveTypes::*;

    cmdT  decCmd;
    modeT decMode;

    opcodeDecoder decoder (
        .opcode (laneByte),
        .cmd    (decCmd),
        .mode   (decMode)
    );

    always_ff @(posedge clk) begin
        if (!rstN) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= byteValid;
        end
    end

    always_ff @(posedge clk) begin
        if (byteValid) begin
            result.cmd  <= decCmd;
            result.mode <= decMode;
            result.len  <= instLength(decMode); // 1 to 3 bytes
        end
    end

    // a result handed to the picker always carries a usable length
    lenNonZero: assert property (@(posedge clk) disable iff (!rstN)
        result.valid |-> result.len != 2'd0);

endmodule

/* logic/boundaryPicker.sv */
`timescale 1ns/10ps

module boundaryPicker (
    input  logic                                 clk,
    input  logic                                 rstN,
    laneResultIf.picker                          lanes [sixFiveTypes::laneCount],
    output logic                                 outValid,
    output logic [sixFiveTypes::laneCount-1:0]   startMask,
    output logic [6*sixFiveTypes::laneCount-1:0] cmdOut,
    output logic [4*sixFiveTypes::laneCount-1:0] modeOut,
    output logic [2*sixFiveTypes::laneCount-1:0] lenOut
);
    import sixFiveTypes::*;

    logic [laneCount-1:0] laneValid;
    cmdT                  laneCmd  [laneCount];
    modeT                 laneMode [laneCount];
    lenT                  laneLen  [laneCount];
    logic                 wordValid;
    logic [1:0]           skipCount; // operand bytes owed from the last word
    logic [1:0]           skipNext;
    logic [laneCount-1:0] maskNext;
    logic [2:0]           nextPos;

    for (genvar i = 0; i < laneCount; i++) begin : unpackLanes
        assign laneValid[i] = lanes[i].valid;
        assign laneCmd[i]   = lanes[i].cmd;
        assign laneMode[i]  = lanes[i].mode;
        assign laneLen[i]   = lanes[i].len;
    end

    assign wordValid = &laneValid; // lanes move in lockstep

    // walk from the carried skip, each start points at the next one
    always_comb begin
        nextPos  = {1'b0, skipCount};
        maskNext = '0;
        for (int p = 0; p < laneCount; p++) begin
            if (nextPos == 3'(p)) begin
                maskNext[p] = 1'b1;
                nextPos     = 3'(p) + {1'b0, laneLen[p]};
            end
        end
        skipNext = (nextPos > 3'(laneCount)) ? 2'(nextPos - 3'(laneCount)) : 2'd0;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            outValid  <= 1'b0;
            skipCount <= 2'd0;
        end else begin
            outValid <= wordValid;
            if (wordValid) begin
                skipCount <= skipNext; // gaps keep the carry
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wordValid) begin
            startMask <= maskNext;
            for (int i = 0; i < laneCount; i++) begin
                cmdOut[6*i +: 6]  <= laneCmd[i];
                modeOut[4*i +: 4] <= laneMode[i];
                lenOut[2*i +: 2]  <= laneLen[i];
            end
        end
    end

    // a 3-byte instruction at lane 3 owes at most two bytes
    skipBound: assert property (@(posedge clk) disable iff (!rstN)
        wordValid |=> skipCount <= 2'd2);

    // skip below 4 means some lane in the word is always a start
    startSeen: assert property (@(posedge clk) disable iff (!rstN)
        outValid |-> startMask != '0);

endmodule

/* logic/predecodeTop.sv */
`timescale 1ns/10ps

module predecodeTop (
    input  logic                                 clk,
    input  logic                                 rstN,
    input  logic                                 fetchValid,
    input  logic [8*sixFiveTypes::laneCount-1:0] fetchData,
    output logic                                 outValid,
    output logic [sixFiveTypes::laneCount-1:0]   startMask,
    output logic [6*sixFiveTypes::laneCount-1:0] cmdOut,
    output logic [4*sixFiveTypes::laneCount-1:0] modeOut,
    output logic [2*sixFiveTypes::laneCount-1:0] lenOut
);
    import sixFiveTypes::*;

    logic   byteValid;
    opcodeT laneByte [laneCount];

    laneResultIf laneRes [laneCount] ();

    fetchWindow window (
        .clk        (clk),
        .rstN       (rstN),
        .fetchValid (fetchValid),
        .fetchData  (fetchData),
        .byteValid  (byteValid),
        .laneByte   (laneByte)
    );

    // every byte decoded as if it were an opcode
    for (genvar i = 0; i < laneCount; i++) begin : laneGen
        predecodeLane decodeLane (
            .clk       (clk),
            .rstN      (rstN),
            .byteValid (byteValid),
            .laneByte  (laneByte[i]),
            .result    (laneRes[i])
        );
    end

    boundaryPicker startPicker (
        .clk       (clk),
        .rstN      (rstN),
        .lanes     (laneRes),
        .outValid  (outValid),
        .startMask (startMask),
        .cmdOut    (cmdOut),
        .modeOut   (modeOut),
        .lenOut    (lenOut)
    );

endmodule

/* bench/opcodeModel.svh */
`ifndef OPCODE_MODEL_SVH
`define OPCODE_MODEL_SVH

// expected command, mode and length for every byte read as an opcode
cmdT  modelCmd  [256];
modeT modelMode [256];
int   modelLen  [256];
int   modelOwed; // operand bytes the stream still owes

// cpx, cpy, ldy and sty share the upper half of the c = 0 column
function automatic cmdT indexCmd(input logic [2:0] a);
    case (a)
        3'd4: return cmdSty;
        3'd5: return cmdLdy;
        3'd6: return cmdCpy;
        default: return cmdCpx;
    endcase
endfunction

function automatic cmdT shiftCmd(input logic [2:0] a);
    case (a)
        3'd4: return cmdStx;
        3'd5: return cmdLdx;
        3'd6: return cmdDec;
        3'd7: return cmdInc;
        default: return cmdT'(cmdAsl + a); // asl rol lsr ror in order
    endcase
endfunction

function automatic modeT aluMode(input logic [2:0] b);
    case (b)
        3'd0: return modeXind;
        3'd1: return modeZpg;
        3'd2: return modeImm;
        3'd3: return modeAbs;
        3'd4: return modeIndY;
        3'd5: return modeZpgX;
        3'd6: return modeAbsY;
        default: return modeAbsX;
    endcase
endfunction

// opcode plus operand bytes
function automatic int modeBytes(input modeT mode);
    if (mode == modeImpl || mode == modeAcc) begin
        return 1;
    end
    if (mode == modeAbs || mode == modeAbsX || mode == modeAbsY || mode == modeInd) begin
        return 3;
    end
    return 2;
endfunction

function automatic void fillModel();
    logic [2:0] a;
    logic [2:0] b;
    cmdT        cmd;
    modeT       mode;
    for (int op = 0; op < 256; op++) begin
        a    = op[7:5];
        b    = op[4:2];
        cmd  = cmdNone;
        mode = modeImpl;
        if (op[1:0] == 2'd1) begin
            cmd  = cmdT'(cmdOra + a);
            mode = aluMode(b);
        end else if (op[1:0] == 2'd0) begin
            case (b)
                3'd0: begin // brk jsr rti rts, then immediates
                    cmd = cmdT'(cmdBrk + a);
                    if (a == 3'd1) begin
                        mode = modeAbs;
                    end
                    if (a >= 3'd4) begin
                        cmd  = (a == 3'd4) ? cmdCpx : indexCmd(a);
                        mode = modeImm;
                    end
                end
                3'd1: begin
                    cmd  = (a <= 3'd1) ? cmdBit : indexCmd(a);
                    mode = modeZpg;
                end
                3'd2: cmd = cmdT'(cmdPhp + a);
                3'd3: begin
                    cmd  = (a == 3'd1) ? cmdBit : indexCmd(a);
                    mode = (a == 3'd3) ? modeInd : modeAbs;
                    if (a == 3'd2 || a == 3'd3) begin
                        cmd = cmdJmp;
                    end
                end
                3'd4: begin
                    cmd  = cmdT'(cmdBpl + a);
                    mode = modeRel;
                end
                3'd5: begin
                    cmd  = (a == 3'd4) ? cmdSty : cmdLdy;
                    mode = modeZpgX;
                end
                3'd6: cmd = cmdT'(cmdClc + a);
                default: begin
                    cmd  = cmdLdy;
                    mode = modeAbsX;
                end
            endcase
        end else begin // c = 3 reads like c = 2
            case (b)
                3'd0: begin
                    cmd  = cmdLdx;
                    mode = modeImm;
                end
                3'd1: begin
                    cmd  = shiftCmd(a);
                    mode = modeZpg;
                end
                3'd2: begin
                    cmd  = cmdT'(cmdAslA + a);
                    mode = (a < 3'd4) ? modeAcc : modeImpl; // shifts act on A
                end
                3'd3: begin
                    cmd  = shiftCmd(a);
                    mode = modeAbs;
                end
                3'd4: cmd = cmdNone; // left unfilled
                3'd5: begin
                    cmd  = shiftCmd(a);
                    mode = (a == 3'd4 || a == 3'd5) ? modeZpgY : modeZpgX;
                end
                3'd6: cmd = (a == 3'd4) ? cmdTxs : cmdTsx;
                default: begin
                    cmd  = (a == 3'd4) ? cmdInc : shiftCmd(a);
                    mode = modeAbsX;
                end
            endcase
        end
        modelCmd[op]  = cmd;
        modelMode[op] = mode;
        modelLen[op]  = modeBytes(mode);
    end
endfunction

// byte-stream view of the start rule, owed bytes carry into the next word
function automatic logic [3:0] walkStarts(input logic [31:0] word);
    logic [3:0] mask;
    mask = '0;
    for (int p = 0; p < 4; p++) begin
        if (modelOwed == 0) begin
            mask[p]   = 1'b1;
            modelOwed = modelLen[word[8*p +: 8]] - 1;
        end else begin
            modelOwed--;
        end
    end
    return mask;
endfunction

`endif

/* bench/predecodeTb.sv */
`timescale 1ns/10ps

module predecodeTb;
    import sixFiveTypes::*;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  mask;
        logic [31:0] sent; // cycle the word was driven
    } expT;

    logic        clk;
    logic        rstN;
    logic        fetchValid;
    logic [31:0] fetchData;
    logic        outValid;
    logic [3:0]  startMask;
    logic [23:0] cmdOut;
    logic [15:0] modeOut;
    logic [7:0]  lenOut;

    int         seed;
    int         cycleCount;
    int         checkCount;
    int         errorCount;
    int         testStartErrors;
    int         wordCount;
    logic       rstSampled; // reset seen by the DUT at the last edge
    string      testName;
    expT        expQ [$];
    logic [7:0] streamQ [$];

    `include "opcodeModel.svh"

    predecodeTop uut (
        .clk        (clk),
        .rstN       (rstN),
        .fetchValid (fetchValid),
        .fetchData  (fetchData),
        .outValid   (outValid),
        .startMask  (startMask),
        .cmdOut     (cmdOut),
        .modeOut    (modeOut),
        .lenOut     (lenOut)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("FAIL %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    task automatic reportError(input string msg);
        errorCount++;
        $display("ERROR in %s: %s", testName, msg);
    endtask

    task automatic checkWord(input expT front);
        logic [7:0] op;
        checkValue({testName, " latency"}, 3, cycleCount - front.sent);
        checkValue({testName, " startMask"}, front.mask, startMask);
        for (int i = 0; i < laneCount; i++) begin
            op = front.data[8*i +: 8];
            checkValue($sformatf("%s lane%0d cmd of %h", testName, i, op),
                       modelCmd[op], cmdOut[6*i +: 6]);
            checkValue($sformatf("%s lane%0d mode of %h", testName, i, op),
                       modelMode[op], modeOut[4*i +: 4]);
            checkValue($sformatf("%s lane%0d len of %h", testName, i, op),
                       modelLen[op], lenOut[2*i +: 2]);
        end
    endtask

    // outputs are read at the falling edge, away from the DUT's updates
    always @(negedge clk) begin : outputMonitor
        expT front;
        if (rstSampled) begin
            if (outValid !== 1'b0) begin
                reportError("outValid was high while reset was applied");
            end
            expQ.delete(); // words in flight are lost to reset
        end else if (outValid === 1'b1) begin
            if (expQ.size() == 0) begin
                reportError("outValid pulsed with no word in flight");
            end else begin
                front = expQ.pop_front();
                checkWord(front);
            end
        end else if (expQ.size() > 0 && cycleCount >= expQ[0].sent + 3) begin
            reportError("outValid never came for a sampled word");
            void'(expQ.pop_front());
        end
        rstSampled = !rstN;
        cycleCount++;
    end

    task automatic sendWord(input logic [31:0] word);
        expT entry;
        @(posedge clk);
        fetchValid <= 1'b1;
        fetchData  <= word;
        entry.data = word;
        entry.mask = walkStarts(word);
        entry.sent = cycleCount;
        expQ.push_back(entry);
        wordCount++;
    endtask

    task automatic idleCycle();
        @(posedge clk);
        fetchValid <= 1'b0;
        fetchData  <= $random(seed); // noise the window must ignore
    endtask

    task automatic waitDrain();
        int waited;
        waited = 0;
        idleCycle();
        while (expQ.size() > 0 && waited < 50) begin
            @(negedge clk);
            waited++;
        end
        if (expQ.size() > 0) begin
            reportError("timed out waiting for outValid on words in flight");
            expQ.delete();
        end
    endtask

    task automatic applyReset();
        @(posedge clk);
        rstN       <= 1'b0;
        fetchValid <= 1'b0;
        repeat (16) @(posedge clk);
        rstN <= 1'b1;
        modelOwed = 0; // stream restarts at byte 0
    endtask

    function automatic logic [7:0] pickOpcode();
        logic [7:0] op;
        op = $random(seed);
        for (int t = 0; t < 16 && modelCmd[op] == cmdNone; t++) begin
            op = $random(seed);
        end
        return op;
    endfunction

    // opcodes with random operands, packed four bytes per word
    task automatic sendStream(input int words, input bit withGaps);
        logic [7:0]  op;
        logic [31:0] word;
        for (int w = 0; w < words; w++) begin
            while (streamQ.size() < laneCount) begin
                op = pickOpcode();
                streamQ.push_back(op);
                for (int k = 1; k < modelLen[op]; k++) begin
                    streamQ.push_back($random(seed));
                end
            end
            for (int i = 0; i < laneCount; i++) begin
                word[8*i +: 8] = streamQ.pop_front();
            end
            if (withGaps) begin
                repeat ({$random(seed)} % 3) idleCycle();
            end
            sendWord(word);
        end
    endtask

    task automatic startTest(input string name);
        testName        = name;
        testStartErrors = errorCount;
        wordCount       = 0;
    endtask

    task automatic finishTest();
        waitDrain();
        $display("test %s: %0d words, %0d errors", testName, wordCount,
                 errorCount - testStartErrors);
    endtask

    initial begin
        seed       = 98;
        rstN       = 1'b0;
        fetchValid = 1'b0;
        fetchData  = '0;
        rstSampled = 1'b0;
        cycleCount = 0;
        checkCount = 0;
        errorCount = 0;
        modelOwed  = 0;
        testName   = "startup";
        fillModel();
        applyReset();

        startTest("opcodeSweep");
        for (int op = 0; op < 256; op++) begin
            sendWord({24'hEAEAEA, 8'(op)}); // swept byte in lane 0, nops behind
        end
        finishTest();

        startTest("mixedStream");
        sendStream(200, 1'b0);
        finishTest();

        startTest("gaps");
        sendStream(200, 1'b1);
        finishTest();

        startTest("latency");
        sendStream(32, 1'b0);
        finishTest();

        startTest("reset");
        streamQ.delete();
        sendStream(6, 1'b0);
        sendWord(32'h4CEAEAEA); // jmp abs at lane 3 owes two bytes
        sendWord(32'hEAEAEAEA); // still in the pipe when reset hits
        sendWord(32'hEAEAEAEA);
        applyReset();
        streamQ.delete();
        sendWord(32'hEAEAEAEA); // stale skip would hide lanes 0 and 1
        sendStream(8, 1'b1);
        finishTest();

        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+bench
logic/sixFiveTypes.sv
logic/laneResultIf.sv
logic/fetchWindow.sv
logic/opcodeDecoder.sv
logic/predecodeLane.sv
logic/boundaryPicker.sv
logic/predecodeTop.sv
bench/predecodeTb.sv
